/* design/coherence_macros.svh */
// ----------------------------------------------------------
// widths and core count for the coherence controller
// CC_CORES sizes the per-core arrays, and the control logic
// assumes exactly two cores
// ----------------------------------------------------------

`ifndef COHERENCE_MACROS_SVH
`define COHERENCE_MACROS_SVH

// bus address width
`define CC_ADDR_W 32

// cache word width
`define CC_DATA_W 32

// cores sharing the memory port
`define CC_CORES 2

`endif

/* design/coherencePkg.sv */
// ----------------------------------------------------------
// request, response, snoop and memory types for the dual-core
// coherence controller
// widths come from coherence_macros.svh
// ----------------------------------------------------------

`include "coherence_macros.svh"

`default_nettype none

package coherencePkg;

  // instruction cache fill request and answer
  typedef struct packed {
    logic                  ren;
    logic [`CC_ADDR_W-1:0] addr;
  } instrReq_t;

  typedef struct packed {
    logic                  iwait;
    logic [`CC_DATA_W-1:0] load;
  } instrRsp_t;

  // ccwrite is "wants exclusive" from the requester and
  // "holds modified" from the snooped peer
  typedef struct packed {
    logic                  dren;
    logic                  dwen;
    logic [`CC_ADDR_W-1:0] addr;
    logic [`CC_DATA_W-1:0] store;
    logic                  cctrans;
    logic                  ccwrite;
  } dataReq_t;

  typedef struct packed {
    logic                  dwait;
    logic [`CC_DATA_W-1:0] load;
  } dataRsp_t;

  typedef struct packed {
    logic                  ccwait;
    logic                  ccinv;
    logic [`CC_ADDR_W-1:0] snoopaddr;
  } snoop_t;

  // internal memory path toward the APB port
  typedef struct packed {
    logic                  ren;
    logic                  wen;
    logic [`CC_ADDR_W-1:0] addr;
    logic [`CC_DATA_W-1:0] wdata;
  } memReq_t;

  typedef struct packed {
    logic                  done;
    logic [`CC_DATA_W-1:0] rdata;
  } memRsp_t;

  typedef enum logic [2:0] {
    IDLE, ARB, SNOOP, WB, C2C, RDMEM
  } ccState_t;

endpackage

`default_nettype wire

/* design/instrFetchArbiter.sv */
// ----------------------------------------------------------
// round-robin arbiter for the two instruction-cache fills
// the grant is locked from first request until memory done
// after reset core 0 wins a simultaneous request
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "coherence_macros.svh"

`default_nettype none

module instrFetchArbiter (
  input  logic                    CLK,
  input  logic                    nRST,
  input  coherencePkg::instrReq_t iReq [`CC_CORES],
  output coherencePkg::instrRsp_t iRsp [`CC_CORES],
  output coherencePkg::memReq_t   fetchMem,
  input  coherencePkg::memRsp_t   fetchRsp
);

  logic lastServed;
  logic grantValid;
  logic grantCore;
  logic pickCore;
  logic reqCore;
  logic anyReq;

  assign anyReq = iReq[0].ren || iReq[1].ren;

  // the core not served last wins a tie
  always_comb begin
    if (iReq[0].ren && iReq[1].ren) begin
      pickCore = ~lastServed;
    end else begin
      pickCore = iReq[1].ren;
    end
  end

  assign reqCore = grantValid ? grantCore : pickCore;

  always_comb begin
    fetchMem.ren   = grantValid || anyReq;
    fetchMem.wen   = 1'b0;
    fetchMem.addr  = iReq[reqCore].addr;
    fetchMem.wdata = '0;
  end

  // lastServed starts at 1 so core 0 goes first
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      grantValid <= 1'b0;
      grantCore  <= 1'b0;
      lastServed <= 1'b1;
    end else if (!grantValid && anyReq) begin
      grantValid <= 1'b1;
      grantCore  <= pickCore;
    end else if (grantValid && fetchRsp.done) begin
      grantValid <= 1'b0;
      lastServed <= grantCore;
    end
  end

  // one-cycle wait-low pulse to the granted core
  always_comb begin
    for (int i = 0; i < `CC_CORES; i++) begin
      iRsp[i].iwait = 1'b1;
      iRsp[i].load  = '0;
    end
    if (grantValid && fetchRsp.done) begin
      iRsp[grantCore].iwait = 1'b0;
      iRsp[grantCore].load  = fetchRsp.rdata;
    end
  end

  iwaitOneHot: assert property (@(posedge CLK) disable iff (!nRST)
    !(!iRsp[0].iwait && !iRsp[1].iwait))
    else $error("both cores saw iwait low in one cycle");

endmodule

`default_nettype wire

/* design/dataCoherenceFsm.sv */
// ----------------------------------------------------------
// MSI snoop sequencer for the two data caches
// one transaction at a time, write-backs before misses,
// core 0 preferred; the snooped cache answers combinationally
// through its own ccwrite and store
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "coherence_macros.svh"

`default_nettype none

module dataCoherenceFsm (
  input  logic                   CLK,
  input  logic                   nRST,
  input  coherencePkg::dataReq_t dReq [`CC_CORES],
  output coherencePkg::dataRsp_t dRsp [`CC_CORES],
  output coherencePkg::snoop_t   snoop [`CC_CORES],
  output coherencePkg::memReq_t  dataMem,
  input  coherencePkg::memRsp_t  dataRsp
);
  import coherencePkg::*;

  ccState_t state;
  ccState_t nextState;
  logic     servedCore;
  logic     arbCore;
  logic     peerCore;
  logic     snoopActive;

  assign peerCore    = ~servedCore;
  assign snoopActive = (state == SNOOP) || (state == C2C) || (state == RDMEM);

  always_comb begin
    if (dReq[0].dwen) begin
      arbCore = 1'b0;
    end else if (dReq[1].dwen) begin
      arbCore = 1'b1;
    end else if (dReq[0].cctrans) begin
      arbCore = 1'b0;
    end else begin
      arbCore = 1'b1;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (dReq[0].dwen || dReq[1].dwen || dReq[0].cctrans || dReq[1].cctrans) begin
          nextState = ARB;
        end
      end
      ARB:   nextState = dReq[arbCore].dwen ? WB : SNOOP;
      // peer answers the snoop in this cycle
      SNOOP: nextState = dReq[peerCore].ccwrite ? C2C : RDMEM;
      WB, C2C, RDMEM: begin
        if (dataRsp.done) begin
          nextState = IDLE;
        end
      end
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= IDLE;
      servedCore <= 1'b0;
    end else begin
      state <= nextState;
      if (state == ARB) begin
        servedCore <= arbCore;
      end
    end
  end

  always_comb begin
    dataMem = '0;
    for (int i = 0; i < `CC_CORES; i++) begin
      dRsp[i].dwait = 1'b1;
      dRsp[i].load  = '0;
      snoop[i]      = '0;
    end
    if (snoopActive) begin
      snoop[peerCore].ccwait    = 1'b1;
      snoop[peerCore].ccinv     = dReq[servedCore].ccwrite;
      snoop[peerCore].snoopaddr = dReq[servedCore].addr;
    end
    case (state)
      WB: begin
        dataMem.wen               = 1'b1;
        dataMem.addr              = dReq[servedCore].addr;
        dataMem.wdata             = dReq[servedCore].store;
        dRsp[servedCore].dwait    = !dataRsp.done;
      end
      // peer's dirty word goes to memory and to the requester at once
      C2C: begin
        dataMem.wen               = 1'b1;
        dataMem.addr              = dReq[servedCore].addr;
        dataMem.wdata             = dReq[peerCore].store;
        dRsp[0].dwait             = !dataRsp.done;
        dRsp[1].dwait             = !dataRsp.done;
        dRsp[servedCore].load     = dReq[peerCore].store;
      end
      RDMEM: begin
        dataMem.ren               = 1'b1;
        dataMem.addr              = dReq[servedCore].addr;
        dRsp[servedCore].dwait    = !dataRsp.done;
        dRsp[servedCore].load     = dataRsp.rdata;
      end
      default: ;
    endcase
  end

  ccinvOnlyPeer: assert property (@(posedge CLK) disable iff (!nRST)
    !snoop[servedCore].ccinv)
    else $error("ccinv sent to the served core");

  memNoReadWrite: assert property (@(posedge CLK) disable iff (!nRST)
    (state != IDLE && state != ARB) |-> !(dataMem.ren && dataMem.wen))
    else $error("data memory request is both read and write");

endmodule

`default_nettype wire

/* design/memPortMux.sv */
// ----------------------------------------------------------
// APB master shared by fetch and data requests
// data wins when a new transfer starts; the owner keeps the
// port until PREADY in the access phase
// no PSLVERR, one idle cycle between transfers
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "coherence_macros.svh"

`default_nettype none

module memPortMux (
  input  logic                   CLK,
  input  logic                   nRST,
  input  coherencePkg::memReq_t  fetchMem,
  input  coherencePkg::memReq_t  dataMem,
  output coherencePkg::memRsp_t  fetchRsp,
  output coherencePkg::memRsp_t  dataRsp,
  output logic                   PSEL,
  output logic                   PENABLE,
  output logic                   PWRITE,
  output logic [`CC_ADDR_W-1:0]  PADDR,
  output logic [`CC_DATA_W-1:0]  PWDATA,
  input  logic [`CC_DATA_W-1:0]  PRDATA,
  input  logic                   PREADY
);
  import coherencePkg::*;

  typedef enum logic [1:0] {
    PH_IDLE, PH_SETUP, PH_ACCESS
  } apbPhase_t;

  apbPhase_t phase;
  logic      ownerData;
  logic      dataPending;
  logic      fetchPending;
  logic      done;
  memReq_t   selReq;

  assign dataPending  = dataMem.ren || dataMem.wen;
  assign fetchPending = fetchMem.ren || fetchMem.wen;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      phase     <= PH_IDLE;
      ownerData <= 1'b0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (dataPending || fetchPending) begin
            phase     <= PH_SETUP;
            ownerData <= dataPending;
          end
        end
        PH_SETUP:  phase <= PH_ACCESS;
        PH_ACCESS: begin
          if (PREADY) begin
            phase <= PH_IDLE;
          end
        end
        default:   phase <= PH_IDLE;
      endcase
    end
  end

  assign selReq  = ownerData ? dataMem : fetchMem;
  assign PSEL    = (phase != PH_IDLE);
  assign PENABLE = (phase == PH_ACCESS);
  assign PWRITE  = PSEL && selReq.wen;
  assign PADDR   = PSEL ? selReq.addr : '0;
  assign PWDATA  = PSEL ? selReq.wdata : '0;
  assign done    = PENABLE && PREADY;

  // response only to the owner
  always_comb begin
    dataRsp.done   = done && ownerData;
    dataRsp.rdata  = ownerData ? PRDATA : '0;
    fetchRsp.done  = done && !ownerData;
    fetchRsp.rdata = ownerData ? '0 : PRDATA;
  end

  apbStable: assert property (@(posedge CLK) disable iff (!nRST)
    (PSEL && !PREADY) |=> ($stable(PADDR) && $stable(PWRITE) && $stable(PWDATA)))
    else $error("APB address or data changed during a transfer");

endmodule

`default_nettype wire

/* design/coherenceTop.sv */
// ----------------------------------------------------------
// dual-core coherence controller with one APB memory port
// fetch arbitration and data coherence run side by side,
// data traffic has priority at the memory port
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "coherence_macros.svh"

`default_nettype none

module coherenceTop (
  input  logic                    CLK,
  input  logic                    nRST,
  input  coherencePkg::instrReq_t iReq [`CC_CORES],
  output coherencePkg::instrRsp_t iRsp [`CC_CORES],
  input  coherencePkg::dataReq_t  dReq [`CC_CORES],
  output coherencePkg::dataRsp_t  dRsp [`CC_CORES],
  output coherencePkg::snoop_t    snoop [`CC_CORES],
  output logic                    PSEL,
  output logic                    PENABLE,
  output logic                    PWRITE,
  output logic [`CC_ADDR_W-1:0]   PADDR,
  output logic [`CC_DATA_W-1:0]   PWDATA,
  input  logic [`CC_DATA_W-1:0]   PRDATA,
  input  logic                    PREADY
);
  import coherencePkg::*;

  memReq_t fetchMem;
  memRsp_t fetchRsp;
  memReq_t dataMem;
  memRsp_t dataRsp;

  instrFetchArbiter instrFetchArbiter_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .iReq     (iReq),
    .iRsp     (iRsp),
    .fetchMem (fetchMem),
    .fetchRsp (fetchRsp)
  );

  dataCoherenceFsm dataCoherenceFsm_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .dReq    (dReq),
    .dRsp    (dRsp),
    .snoop   (snoop),
    .dataMem (dataMem),
    .dataRsp (dataRsp)
  );

  memPortMux memPortMux_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .fetchMem (fetchMem),
    .dataMem  (dataMem),
    .fetchRsp (fetchRsp),
    .dataRsp  (dataRsp),
    .PSEL     (PSEL),
    .PENABLE  (PENABLE),
    .PWRITE   (PWRITE),
    .PADDR    (PADDR),
    .PWDATA   (PWDATA),
    .PRDATA   (PRDATA),
    .PREADY   (PREADY)
  );

endmodule

`default_nettype wire

/* bench/apbRamModel.sv */
// ----------------------------------------------------------
// APB slave memory, 256 words at byte addresses 0x000-0x3fc
// upper address bits alias, no PSLVERR
// waitStates cycles pass in the access phase before PREADY
// the preload port writes one word per clock between transfers
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "coherence_macros.svh"

`default_nettype none

module apbRamModel (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  PSEL,
  input  logic                  PENABLE,
  input  logic                  PWRITE,
  input  logic [`CC_ADDR_W-1:0] PADDR,
  input  logic [`CC_DATA_W-1:0] PWDATA,
  output logic [`CC_DATA_W-1:0] PRDATA,
  output logic                  PREADY,
  input  logic [7:0]            waitStates,
  input  logic                  preloadEn,
  input  logic [`CC_ADDR_W-1:0] preloadAddr,
  input  logic [`CC_DATA_W-1:0] preloadData
);

  logic [`CC_DATA_W-1:0] mem [256];
  logic [7:0]            waitCount;
  logic [7:0]            wordIndex;

  assign wordIndex = PADDR[9:2];
  assign PREADY    = PSEL && PENABLE && (waitCount >= waitStates);
  assign PRDATA    = mem[wordIndex];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      waitCount <= '0;
      // fill word built from its byte address
      for (int i = 0; i < 256; i++) begin
        mem[i] <= {~16'(i * 4), 16'(i * 4)};
      end
    end else begin
      if (preloadEn) begin
        mem[preloadAddr[9:2]] <= preloadData;
      end
      if (PSEL && PENABLE) begin
        if (PREADY) begin
          waitCount <= '0;
          if (PWRITE) begin
            mem[wordIndex] <= PWDATA;
          end
        end else begin
          waitCount <= waitCount + 8'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/coherenceTb.sv */
// ----------------------------------------------------------
// testbench for coherenceTop, one transaction per data line
// reads bench/coherence_testdata.txt, run from the project root
// the peer cache answers a snoop with steady ccwrite and store
// stops at the first error
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "coherence_macros.svh"

`default_nettype none

module coherenceTb;
  import coherencePkg::*;

  localparam int maxLines      = 64;
  localparam int timeoutCycles = 200;

  typedef struct packed {
    logic [3:0]  kind;
    logic [3:0]  core;
    logic [7:0]  waits;
    logic [3:0]  peerMod;
    logic [3:0]  excl;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expLoad;
  } testLine_t;

  logic                  CLK;
  logic                  nRST;
  instrReq_t             iReq [`CC_CORES];
  instrRsp_t             iRsp [`CC_CORES];
  dataReq_t              dReq [`CC_CORES];
  dataRsp_t              dRsp [`CC_CORES];
  snoop_t                snoop [`CC_CORES];
  logic                  PSEL;
  logic                  PENABLE;
  logic                  PWRITE;
  logic                  PREADY;
  logic [`CC_ADDR_W-1:0] PADDR;
  logic [`CC_DATA_W-1:0] PWDATA;
  logic [`CC_DATA_W-1:0] PRDATA;
  logic [7:0]            waitStates;
  logic                  preloadEn;
  logic [`CC_ADDR_W-1:0] preloadAddr;
  logic [`CC_DATA_W-1:0] preloadData;
  logic [119:0]          rawLines [maxLines];
  logic                  lastFill;
  logic                  postValid;
  logic                  postCore;
  logic [31:0]           postAddr;
  logic [31:0]           postLoad;

  coherenceTop coherenceTop_i (
    .CLK     (CLK),
    .nRST    (nRST),
    .iReq    (iReq),
    .iRsp    (iRsp),
    .dReq    (dReq),
    .dRsp    (dRsp),
    .snoop   (snoop),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY)
  );

  apbRamModel apbRamModel_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .PSEL        (PSEL),
    .PENABLE     (PENABLE),
    .PWRITE      (PWRITE),
    .PADDR       (PADDR),
    .PWDATA      (PWDATA),
    .PRDATA      (PRDATA),
    .PREADY      (PREADY),
    .waitStates  (waitStates),
    .preloadEn   (preloadEn),
    .preloadAddr (preloadAddr),
    .preloadData (preloadData)
  );

  always #2 CLK = ~CLK;

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic reportMismatch(input string sig, input logic [63:0] got,
                                input logic [63:0] exp);
    stopOnError($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", sig, got, exp));
  endtask

  task automatic checkInstrRsp(input string name, input instrRsp_t act,
                               input instrRsp_t exp, input bit withLoad);
    if (act.iwait !== exp.iwait) begin
      reportMismatch({name, ".iwait"}, 64'(act.iwait), 64'(exp.iwait));
    end
    if (withLoad && act.load !== exp.load) begin
      reportMismatch({name, ".load"}, 64'(act.load), 64'(exp.load));
    end
  endtask

  task automatic checkDataRsp(input string name, input dataRsp_t act,
                              input dataRsp_t exp, input bit withLoad);
    if (act.dwait !== exp.dwait) begin
      reportMismatch({name, ".dwait"}, 64'(act.dwait), 64'(exp.dwait));
    end
    if (withLoad && act.load !== exp.load) begin
      reportMismatch({name, ".load"}, 64'(act.load), 64'(exp.load));
    end
  endtask

  // snoopaddr only matters while ccwait is up
  task automatic checkSnoop(input string name, input snoop_t act, input snoop_t exp);
    if (act.ccwait !== exp.ccwait) begin
      reportMismatch({name, ".ccwait"}, 64'(act.ccwait), 64'(exp.ccwait));
    end
    if (act.ccinv !== exp.ccinv) begin
      reportMismatch({name, ".ccinv"}, 64'(act.ccinv), 64'(exp.ccinv));
    end
    if (exp.ccwait && act.snoopaddr !== exp.snoopaddr) begin
      reportMismatch({name, ".snoopaddr"}, 64'(act.snoopaddr), 64'(exp.snoopaddr));
    end
  endtask

  task automatic checkMemWord(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
    if (act !== exp) begin
      reportMismatch(name, 64'(act), 64'(exp));
    end
  endtask

  task automatic stepToDrive();
    @(posedge CLK);
    #1;
  endtask

  task automatic checkResetState();
    instrRsp_t idleInstr;
    dataRsp_t  idleData;
    idleInstr = '{iwait: 1'b1, load: '0};
    idleData  = '{dwait: 1'b1, load: '0};
    @(negedge CLK);
    for (int c = 0; c < `CC_CORES; c++) begin
      checkInstrRsp($sformatf("iRsp[%0d]", c), iRsp[c], idleInstr, 1'b0);
      checkDataRsp($sformatf("dRsp[%0d]", c), dRsp[c], idleData, 1'b0);
      checkSnoop($sformatf("snoop[%0d]", c), snoop[c], '0);
    end
    if (PSEL !== 1'b0) begin
      reportMismatch("PSEL", 64'(PSEL), 64'h0);
    end
    if (PENABLE !== 1'b0) begin
      reportMismatch("PENABLE", 64'(PENABLE), 64'h0);
    end
    stepToDrive();
  endtask

  task automatic preloadWord(input logic [31:0] addr, input logic [31:0] data);
    stepToDrive();
    preloadEn   = 1'b1;
    preloadAddr = addr;
    preloadData = data;
    stepToDrive();
    preloadEn = 1'b0;
  endtask

  // returns at drive time after the iwait pulse
  task automatic waitFill(input logic core, input logic [31:0] expLoad);
    int        cycles;
    logic      finished;
    instrRsp_t busy;
    instrRsp_t served;
    cycles   = 0;
    finished = 1'b0;
    busy     = '{iwait: 1'b1, load: '0};
    served   = '{iwait: 1'b0, load: expLoad};
    while (!finished) begin
      @(negedge CLK);
      cycles++;
      checkInstrRsp($sformatf("iRsp[%0d]", ~core), iRsp[~core], busy, 1'b0);
      if (!iRsp[core].iwait) begin
        checkInstrRsp($sformatf("iRsp[%0d]", core), iRsp[core], served, 1'b1);
        lastFill = core;
        finished = 1'b1;
      end else if (cycles >= timeoutCycles) begin
        stopOnError($sformatf("timeout waiting for the fill of core %0d", core));
      end
      stepToDrive();
    end
  endtask

  task automatic runFill(input testLine_t line);
    stepToDrive();
    waitStates          = line.waits;
    iReq[line.core[0]]  = '{ren: 1'b1, addr: line.addr};
    waitFill(line.core[0], line.expLoad);
    iReq[line.core[0]]  = '0;
  endtask

  // core 1 fetches addr+4 and expects the wdata word
  task automatic runDualFill(input testLine_t line);
    logic first;
    first = ~lastFill;
    stepToDrive();
    waitStates = line.waits;
    iReq[0]    = '{ren: 1'b1, addr: line.addr};
    iReq[1]    = '{ren: 1'b1, addr: line.addr + 32'd4};
    if (first == 1'b0) begin
      waitFill(1'b0, line.expLoad);
      iReq[0] = '0;
      waitFill(1'b1, line.wdata);
      iReq[1] = '0;
    end else begin
      waitFill(1'b1, line.wdata);
      iReq[1] = '0;
      waitFill(1'b0, line.expLoad);
      iReq[0] = '0;
    end
  endtask

  task automatic runData(input testLine_t line, input bit isWb);
    logic     req;
    logic     peer;
    logic     c2c;
    logic     pulse;
    logic     issued;
    logic     portBusy;
    int       cycles;
    snoop_t   busySnoop;
    dataRsp_t waitRsp;
    dataRsp_t doneRsp;
    dataRsp_t peerDone;
    req       = line.core[0];
    peer      = ~req;
    c2c       = !isWb && line.peerMod[0];
    busySnoop = '{ccwait: 1'b1, ccinv: !isWb && line.excl[0], snoopaddr: line.addr};
    waitRsp   = '{dwait: 1'b1, load: '0};
    doneRsp   = '{dwait: 1'b0, load: line.expLoad};
    peerDone  = '{dwait: 1'b0, load: '0};
    stepToDrive();
    waitStates = line.waits;
    dReq[req]  = '{dren: !isWb, dwen: isWb, addr: line.addr,
                   store: isWb ? line.wdata : 32'h0, cctrans: !isWb,
                   ccwrite: !isWb && line.excl[0]};
    dReq[peer] = '{dren: 1'b0, dwen: 1'b0, addr: '0, store: line.wdata,
                   cctrans: 1'b0, ccwrite: c2c};
    cycles = 0;
    pulse  = 1'b0;
    issued = 1'b0;
    while (!pulse) begin
      @(negedge CLK);
      cycles++;
      portBusy = PSEL;
      checkSnoop($sformatf("snoop[%0d]", req), snoop[req], '0);
      // peer snooped from the third cycle until done
      checkSnoop($sformatf("snoop[%0d]", peer), snoop[peer],
                 (!isWb && cycles >= 3) ? busySnoop : '0);
      if (PSEL) begin
        checkMemWord("PADDR", PADDR, line.addr);
        if (PWRITE !== (isWb || c2c)) begin
          reportMismatch("PWRITE", 64'(PWRITE), 64'(isWb || c2c));
        end
        if (isWb || c2c) begin
          checkMemWord("PWDATA", PWDATA, line.wdata);
        end
      end
      if (postValid && !iRsp[postCore].iwait) begin
        stopOnError("the fetch finished before the data transaction");
      end
      if (!dRsp[req].dwait) begin
        checkDataRsp($sformatf("dRsp[%0d]", req), dRsp[req], doneRsp, 1'b1);
        checkDataRsp($sformatf("dRsp[%0d]", peer), dRsp[peer], c2c ? peerDone : waitRsp, 1'b0);
        // dwait drops only in the APB access phase
        if (PENABLE !== 1'b1) begin
          reportMismatch("PENABLE", 64'(PENABLE), 64'h1);
        end
        if (cycles < 4) begin
          stopOnError("the data transaction ended in under four cycles");
        end
        if (postValid && !issued) begin
          stopOnError("the fetch was never issued during the data transaction");
        end
        pulse = 1'b1;
      end else begin
        checkDataRsp($sformatf("dRsp[%0d]", peer), dRsp[peer], waitRsp, 1'b0);
        if (cycles >= timeoutCycles) begin
          stopOnError($sformatf("timeout waiting for dwait on core %0d", req));
        end
      end
      stepToDrive();
      // fetch arrives once the data transfer holds the port
      if (postValid && !issued && portBusy && !pulse) begin
        iReq[postCore] = '{ren: 1'b1, addr: postAddr};
        issued         = 1'b1;
      end
    end
    dReq[0] = '0;
    dReq[1] = '0;
    if (postValid) begin
      waitFill(postCore, postLoad);
      iReq[postCore] = '0;
      postValid      = 1'b0;
    end
  endtask

  initial begin
    testLine_t line;
    int        n;
    logic      atEnd;
    CLK         = 1'b0;
    nRST        = 1'b0;
    iReq[0]     = '0;
    iReq[1]     = '0;
    dReq[0]     = '0;
    dReq[1]     = '0;
    waitStates  = '0;
    preloadEn   = 1'b0;
    preloadAddr = '0;
    preloadData = '0;
    lastFill    = 1'b1;
    postValid   = 1'b0;
    postCore    = 1'b0;
    postAddr    = '0;
    postLoad    = '0;
    $readmemh("bench/coherence_testdata.txt", rawLines);
    repeat (5) @(posedge CLK);
    #1;
    nRST = 1'b1;
    checkResetState();
    n     = 0;
    atEnd = 1'b0;
    while (!atEnd) begin
      if (n >= maxLines) begin
        stopOnError("the test data has no end record");
      end
      line = testLine_t'(rawLines[n]);
      case (line.kind)
        4'h0: preloadWord(line.addr, line.wdata);
        4'h1: runFill(line);
        4'h2: runDualFill(line);
        4'h3: runData(line, 1'b1);
        4'h4: runData(line, 1'b0);
        4'h5: begin
          postValid = 1'b1;
          postCore  = line.core[0];
          postAddr  = line.addr;
          postLoad  = line.expLoad;
        end
        4'hf: atEnd = 1'b1;
        default: stopOnError($sformatf("unknown record kind in test data line %0d", n));
      endcase
      n++;
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/coherencePkg.sv
design/instrFetchArbiter.sv
design/dataCoherenceFsm.sv
design/memPortMux.sv
design/coherenceTop.sv
bench/apbRamModel.sv
bench/coherenceTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the coherence testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f sim.f --top-module coherenceTb -o coherenceSim &&
  ./obj_dir/coherenceSim | tee /dev/stderr | grep -q "TB PASSED" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* bench/coherence_testdata.txt */
// columns: kind_core_wait_peerMod_excl_addr_wdata_expLoad (hex)
// kind 0 preload, 1 fill, 2 fill both cores (core 1 at addr+4, wdata its word)
// kind 3 write-back, 4 read miss (wdata is the peer's word), 5 fill during next op, f end
0_0_00_0_0_00000040_11110040_00000000
0_0_00_0_0_00000044_22220044_00000000
0_0_00_0_0_00000080_33330080_00000000
0_0_00_0_0_000000c0_444400c0_00000000
0_0_00_0_0_00000100_55550100_00000000
0_0_00_0_0_00000104_66660104_00000000
// instruction fills
1_1_00_0_0_00000040_00000000_11110040
2_0_01_0_0_00000040_22220044_11110040
1_0_02_0_0_00000044_00000000_22220044
2_0_00_0_0_00000100_66660104_55550100
// write-back then fill of the same word
3_0_01_0_0_00000080_aaaa0080_00000000
1_1_00_0_0_00000080_00000000_aaaa0080
// misses, clean peer then modified peer
4_1_00_0_0_000000c0_00000000_444400c0
4_0_02_0_1_00000040_00000000_11110040
4_0_01_1_0_00000100_bbbb0100_bbbb0100
1_0_00_0_0_00000100_00000000_bbbb0100
4_1_03_1_1_00000044_cccc0044_cccc0044
1_1_01_0_0_00000044_00000000_cccc0044
// fetch held off by a data transaction
5_1_00_0_0_000000c0_00000000_444400c0
3_1_03_0_0_00000140_dddd0140_00000000
1_0_00_0_0_00000140_00000000_dddd0140
5_0_00_0_0_00000080_00000000_aaaa0080
4_1_02_1_0_00000104_eeee0104_eeee0104
1_1_01_0_0_00000104_00000000_eeee0104
f_0_00_0_0_00000000_00000000_00000000
